//--- arp_reply.f
source/arp_pkg.sv
source/arp_fifo.sv
source/arp_request_parser.sv
source/arp_reply_writer.sv
source/arp_reply.sv
dv/arp_reply_properties.sv
dv/arp_reply_tb.sv

//--- dv/arp_reply_properties.sv
// handshake and reset checks bound onto the arp responder top
`timescale 1ns/1ps

module arp_reply_properties (
   input logic               clk,
   input logic               reset,
   input logic               in_wr,
   input logic               in_rdy,
   input arp_pkg::pkt_word_t out_word,
   input logic               out_wr,
   input logic               out_rdy
);

   ////////////////////////////////////////
   // output stream
   ////////////////////////////////////////
   // a word only leaves after a cycle with out_rdy high
   property out_wr_after_rdy;
      @(posedge clk) disable iff (reset)
         out_wr |-> $past(out_rdy);
   endproperty

   out_wr_after_rdy_a : assert property (out_wr_after_rdy)
      else $error("out_wr went high without out_rdy in the previous cycle");

   ////////////////////////////////////////
   // input stream
   ////////////////////////////////////////
   property in_wr_only_when_ready;
      @(posedge clk) disable iff (reset)
         in_wr |-> in_rdy;
   endproperty

   in_wr_only_when_ready_a : assert property (in_wr_only_when_ready)
      else $error("in_wr arrived while in_rdy was low");

   ////////////////////////////////////////
   // reset values
   ////////////////////////////////////////
   property idle_in_reset;
      @(posedge clk) reset |=> (!out_wr && out_word.ctrl == 8'd1);
   endproperty

   idle_in_reset_a : assert property (idle_in_reset)
      else $error("out_wr or out_word.ctrl wrong during reset");

   // both FIFOs empty again, so the input is open
   property ready_after_reset;
      @(posedge clk) $fell(reset) |-> in_rdy;
   endproperty

   ready_after_reset_a : assert property (ready_after_reset)
      else $error("in_rdy low one cycle after reset dropped");

endmodule

bind arp_reply arp_reply_properties props_i (.*);

//--- dv/arp_reply_tb.sv
// testbench for the arp responder that builds packets and checks them against a reference model
`timescale 1ns/1ps

module arp_reply_tb;

   localparam logic [31:0] seed    = 32'hf59b_a8c1;
   localparam int          timeout = 2000;   // cycles per wait

   typedef struct packed {
      logic [15:0] src_port;
      logic [15:0] dst_port;
      logic [47:0] eth_dst;
      logic [47:0] eth_src;
      logic [15:0] ethertype;
      logic [15:0] hw;
      logic [15:0] proto;
      logic [15:0] opcode;
      logic [47:0] sha;
      logic [31:0] spa;
      logic [47:0] tha;
      logic [31:0] tpa;
      logic [63:0] pad;
   } pkt_fields_t;

   typedef arp_pkg::pkt_word_t [7:0] pkt_words_t;

   logic                 clk;
   logic                 reset;
   arp_pkg::pkt_word_t   in_word;
   logic                 in_wr;
   logic                 in_rdy;
   arp_pkg::arp_config_t cfg;
   arp_pkg::pkt_word_t   out_word;
   logic                 out_wr;
   logic                 out_rdy;

   arp_pkg::pkt_word_t exp_q[$];    // expected output words in order
   int                 errors;
   logic [31:0]        stim_state;
   logic [31:0]        rdy_state;
   logic               random_rdy;
   logic               use_gaps;

   arp_reply arp_reply_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function logic [31:0] next_rand();
      stim_state = xorshift(stim_state);
      return stim_state;
   endfunction

   ////////////////////////////////////////
   // packet builder and reference model
   ////////////////////////////////////////
   function automatic pkt_words_t build_words(input pkt_fields_t f);
      pkt_words_t w;
      w[0] = {8'hff, 32'h0, f.src_port, f.dst_port};   // module header
      w[1] = {8'h00, f.eth_dst, f.eth_src[47:32]};
      w[2] = {8'h00, f.eth_src[31:0], f.ethertype, f.hw};
      w[3] = {8'h00, f.proto, 8'd6, 8'd4, f.opcode, f.sha[47:32]};
      w[4] = {8'h00, f.sha[31:0], f.spa};
      w[5] = {8'h00, f.tha, f.tpa[31:16]};
      w[6] = {8'h00, f.tpa[15:0], f.pad[47:0]};
      w[7] = {8'h0f, f.pad};                           // byte mask on last word
      return w;
   endfunction

   function automatic pkt_words_t expected_words(input pkt_fields_t f);
      pkt_fields_t e;
      logic [47:0] our_mac;
      logic        answer;
      e       = f;
      our_mac = cfg.port[f.src_port[2:1]].mac;
      answer  = cfg.enable && f.ethertype == 16'h0806 && f.hw == 16'h0001 &&
                f.proto == 16'h0800 && f.opcode == 16'd1 &&
                f.src_port < 16'd8 && !f.src_port[0] &&
                f.tpa == cfg.port[f.src_port[2:1]].ip;
      if (answer) begin
         e.src_port = 16'd17;
         e.dst_port = 16'd1 << f.src_port[3:0];   // straight back out
         e.eth_dst  = f.sha;
         e.eth_src  = our_mac;
         e.opcode   = 16'd2;
         e.sha      = our_mac;
         e.spa      = f.tpa;
         e.tha      = f.sha;
         e.tpa      = f.spa;
      end
      return build_words(e);
   endfunction

   function automatic pkt_fields_t base_request(input logic [15:0] port,
                                                input logic [31:0] tpa);
      pkt_fields_t f;
      f.src_port  = port;
      f.dst_port  = 16'h0;
      f.eth_dst   = 48'hffff_ffff_ffff;
      f.eth_src   = 48'h00aa_bbcc_dd01;
      f.ethertype = 16'h0806;
      f.hw        = 16'h0001;
      f.proto     = 16'h0800;
      f.opcode    = 16'd1;
      f.sha       = 48'h00aa_bbcc_dd01;
      f.spa       = 32'hc0a8_0105;
      f.tha       = 48'h0;
      f.tpa       = tpa;
      f.pad       = 64'h5a5a_1234_a5a5_9876;
      return f;
   endfunction

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   task automatic fail_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("tests failed");
      $finish;
   endtask

   task automatic drive_word(input arp_pkg::pkt_word_t w);
      int t;
      t = 0;
      while (!in_rdy) begin
         @(posedge clk);
         #1;
         t++;
         if (t > timeout) fail_timeout("in_rdy");
      end
      in_word = w;
      in_wr   = 1'b1;
      @(posedge clk);
      #1;
      in_wr = 1'b0;
   endtask

   task automatic send_packet(input pkt_fields_t f);
      pkt_words_t w;
      pkt_words_t e;
      w = build_words(f);
      e = expected_words(f);
      for (int i = 0; i < 8; i++) exp_q.push_back(e[i]);
      for (int i = 0; i < 8; i++) begin
         drive_word(w[i]);
         if (use_gaps) begin
            repeat (next_rand() % 3) begin   // idle gap
               @(posedge clk);
               #1;
            end
         end
      end
   endtask

   task automatic drain();
      int t;
      t = 0;
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #1;
         t++;
         if (t > timeout) fail_timeout("the output to drain");
      end
   endtask

   // out_rdy pattern with its own sequence
   initial begin
      out_rdy   = 1'b1;
      rdy_state = ~seed;
      forever begin
         @(posedge clk);
         #1;
         if (random_rdy) begin
            rdy_state = xorshift(rdy_state);
            out_rdy   = (rdy_state[3:0] > 4'd4);
         end else begin
            out_rdy = 1'b1;
         end
      end
   end

   // scoreboard samples at the falling edge where outputs are stable
   always @(negedge clk) begin
      arp_pkg::pkt_word_t exp;
      if (!reset && out_wr) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("output word arrived with no packet expected");
         end else begin
            exp = exp_q.pop_front();
            assert (out_word.ctrl == exp.ctrl) else begin
               errors++;
               $display("Error out_word.ctrl expected %h got %h", exp.ctrl, out_word.ctrl);
            end
            assert (out_word.data == exp.data) else begin
               errors++;
               $display("Error out_word.data expected %h got %h", exp.data, out_word.data);
            end
         end
      end
   end

   initial begin
      pkt_fields_t f;
      errors     = 0;
      stim_state = seed;
      random_rdy = 1'b0;
      use_gaps   = 1'b0;
      reset      = 1'b1;
      in_wr      = 1'b0;
      in_word    = '0;
      cfg.enable = 1'b1;
      for (int n = 0; n < arp_pkg::num_ports; n++) begin
         cfg.port[n].ip  = 32'hc0a8_0a00 + n;
         cfg.port[n].mac = 48'h0200_5e00_0010 + 48'(n);
      end
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      // request on port 2 for entry 1
      send_packet(base_request(16'd2, cfg.port[1].ip));
      drain();

      // plain ip packet
      f           = base_request(16'd0, cfg.port[0].ip);
      f.ethertype = 16'h0800;
      send_packet(f);
      // unknown target then an odd port
      send_packet(base_request(16'd4, 32'h0a0b_0c0d));
      send_packet(base_request(16'd3, cfg.port[1].ip));
      drain();

      // responder disabled
      cfg.enable = 1'b0;
      send_packet(base_request(16'd2, cfg.port[1].ip));
      drain();
      cfg.enable = 1'b1;

      ////////////////////////////////////////
      // random mix under back-pressure
      ////////////////////////////////////////
      random_rdy = 1'b1;
      use_gaps   = 1'b1;
      for (int p = 0; p < 40; p++) begin
         f          = base_request(16'(next_rand() % 8), 32'h0);
         f.tpa      = next_rand();
         if (next_rand() % 4 != 0) f.tpa = cfg.port[f.src_port[2:1]].ip;
         if (next_rand() % 5 == 0) f.ethertype = 16'h86dd;
         if (next_rand() % 6 == 0) f.opcode = 16'd2;
         f.sha      = 48'({next_rand(), next_rand()});
         f.spa      = next_rand();
         f.pad      = {next_rand(), next_rand()};
         send_packet(f);
      end
      drain();
      random_rdy = 1'b0;
      repeat (4) @(posedge clk);

      $display("errors %0d, words left %0d", errors, exp_q.size());
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the arp responder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   --top-module arp_reply_tb \
   -f arp_reply.f \
   -o arp_reply_sim

# the log decides pass or fail, so a nonzero exit here is not fatal
./obj_dir/arp_reply_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
   exit 0
else
   exit 1
fi

//--- source/arp_fifo.sv
// fall-through FIFO with a nearly-full flag at two free entries
`timescale 1ns/1ps

module arp_fifo #(
   parameter int width      = 72,
   parameter int depth_bits = 4
) (
   input  logic             clk,
   input  logic             reset,
   input  logic [width-1:0] din,
   input  logic             wr_en,
   input  logic             rd_en,
   output logic [width-1:0] dout,
   output logic             empty,
   output logic             nearly_full
);

   logic [width-1:0]      mem [2**depth_bits];
   logic [depth_bits-1:0] wr_ptr;
   logic [depth_bits-1:0] rd_ptr;
   logic [depth_bits:0]   count;      // msb set means full
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr_en && !count[depth_bits];
   assign do_rd = rd_en && !empty;

   assign empty       = (count == '0);
   assign nearly_full = (count >= (depth_bits+1)'(2**depth_bits - 2));
   assign dout        = mem[rd_ptr];    // head is visible without a read

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         count <= count + {{depth_bits{1'b0}}, do_wr} - {{depth_bits{1'b0}}, do_rd};
      end
   end

endmodule

//--- source/arp_pkg.sv
// arp responder package with stream, config and summary types plus FSM state encodings
package arp_pkg;

   ////////////////////////////////////////
   // stream widths
   ////////////////////////////////////////
   localparam int data_width = 64;
   localparam int ctrl_width = 8;
   localparam int num_ports  = 4;      // ip/mac pairs, one per even phys port

   ////////////////////////////////////////
   // module header word
   ////////////////////////////////////////
   localparam logic [ctrl_width-1:0] ioq_stage_ctrl = 8'hff;
   localparam int ioq_src_port_pos = 16;   // 16-bit field
   localparam int ioq_dst_port_pos = 0;    // 16-bit field, one-hot

   // source port written into replies so the output lookup leaves them alone
   localparam logic [15:0] dont_touch_src_port = 16'd17;

   ////////////////////////////////////////
   // ethernet and arp values
   ////////////////////////////////////////
   localparam logic [15:0] eth_type_arp    = 16'h0806;
   localparam logic [15:0] arp_hw_ethernet = 16'h0001;
   localparam logic [15:0] arp_proto_ip    = 16'h0800;

   typedef enum logic [15:0] {
      arp_request = 16'd1,
      arp_reply   = 16'd2
   } arp_opcode_e;

   // one word of the packet stream
   typedef struct packed {
      logic [ctrl_width-1:0] ctrl;   // 0 mid packet, byte mask on last word
      logic [data_width-1:0] data;
   } pkt_word_t;

   typedef struct packed {
      logic [31:0] ip;
      logic [47:0] mac;
   } port_addr_t;

   typedef struct packed {
      logic                            enable;
      port_addr_t [num_ports-1:0]      port;   // entry n serves phys port 2n
   } arp_config_t;

   // one per packet, parser to writer
   typedef struct packed {
      logic        reply;        // rewrite this packet into a reply
      logic [47:0] sender_mac;
      logic [31:0] sender_ip;
      logic [47:0] our_mac;      // mac of the matched port
      logic [31:0] target_ip;
   } arp_summary_t;

   ////////////////////////////////////////
   // FSM states
   ////////////////////////////////////////
   typedef enum logic [2:0] {
      skip_hdr,
      check_ethertype,
      check_op,
      get_sender,
      get_tpa_hi,
      get_tpa_lo,
      decide,
      wait_eop
   } parse_state_e;

   typedef enum logic [1:0] {
      wait_summary,
      pass_hdr,
      rewrite,
      pass_rest
   } rewrite_state_e;

endpackage

//--- source/arp_reply.sv
// arp responder top, parser and packet FIFO in front of the reply writer
`timescale 1ns/1ps

module arp_reply (
   input  logic                 clk,
   input  logic                 reset,

   // input stream
   input  arp_pkg::pkt_word_t   in_word,
   input  logic                 in_wr,
   output logic                 in_rdy,

   input  arp_pkg::arp_config_t cfg,    // enable and per port ip/mac

   // output stream
   output arp_pkg::pkt_word_t   out_word,
   output logic                 out_wr,
   input  logic                 out_rdy
);

   arp_pkg::pkt_word_t    pkt_head;
   logic                  pkt_empty;
   logic                  pkt_rd;
   logic                  pkt_nearly_full;

   arp_pkg::arp_summary_t summary_in;
   arp_pkg::arp_summary_t summary_head;
   logic                  summary_wr;
   logic                  summary_empty;
   logic                  summary_rd;
   logic                  summary_nearly_full;

   assign in_rdy = !pkt_nearly_full && !summary_nearly_full;

   ////////////////////////////////////////
   // producer side
   ////////////////////////////////////////
   arp_request_parser parser_i (
      .clk        (clk),
      .reset      (reset),
      .in_word    (in_word),
      .in_wr      (in_wr),
      .cfg        (cfg),
      .summary    (summary_in),
      .summary_wr (summary_wr)
   );

   arp_fifo #(
      .width      ($bits(arp_pkg::pkt_word_t)),
      .depth_bits (4)
   ) pkt_fifo (
      .clk         (clk),
      .reset       (reset),
      .din         (in_word),        // whole packet, untouched
      .wr_en       (in_wr),
      .rd_en       (pkt_rd),
      .dout        (pkt_head),
      .empty       (pkt_empty),
      .nearly_full (pkt_nearly_full)
   );

   arp_fifo #(
      .width      ($bits(arp_pkg::arp_summary_t)),
      .depth_bits (2)
   ) summary_fifo (
      .clk         (clk),
      .reset       (reset),
      .din         (summary_in),
      .wr_en       (summary_wr),
      .rd_en       (summary_rd),
      .dout        (summary_head),
      .empty       (summary_empty),
      .nearly_full (summary_nearly_full)
   );

   ////////////////////////////////////////
   // consumer side
   ////////////////////////////////////////
   arp_reply_writer writer_i (
      .clk           (clk),
      .reset         (reset),
      .pkt           (pkt_head),
      .pkt_empty     (pkt_empty),
      .pkt_rd        (pkt_rd),
      .summary       (summary_head),
      .summary_empty (summary_empty),
      .summary_rd    (summary_rd),
      .out_word      (out_word),
      .out_wr        (out_wr),
      .out_rdy       (out_rdy)
   );

endmodule

//--- source/arp_reply_writer.sv
// arp reply writer, forwards packets and rewrites answered requests into replies
`timescale 1ns/1ps

module arp_reply_writer (
   input  logic                  clk,
   input  logic                  reset,
   input  arp_pkg::pkt_word_t    pkt,
   input  logic                  pkt_empty,
   output logic                  pkt_rd,
   input  arp_pkg::arp_summary_t summary,
   input  logic                  summary_empty,
   output logic                  summary_rd,
   output arp_pkg::pkt_word_t    out_word,
   output logic                  out_wr,
   input  logic                  out_rdy
);

   arp_pkg::rewrite_state_e       state;
   arp_pkg::rewrite_state_e       state_nxt;
   logic [2:0]                    count;        // ethernet word index
   logic [2:0]                    count_nxt;
   logic                          prev_is_0;    // last word read had ctrl 0
   logic                          can_go;
   logic                          hdr_go;
   logic [15:0]                   src_onehot;
   logic [arp_pkg::data_width-1:0] out_data_nxt;

   assign can_go     = !pkt_empty && out_rdy;
   assign src_onehot = 16'd1 << pkt.data[arp_pkg::ioq_src_port_pos +: 4];

   // header words move only once the packet's summary is at the head
   assign hdr_go = can_go && (state == arp_pkg::pass_hdr ||
                              (state == arp_pkg::wait_summary && !summary_empty));

   ////////////////////////////////////////
   // next word and state
   ////////////////////////////////////////
   always_comb begin
      state_nxt    = state;
      count_nxt    = count;
      pkt_rd       = 1'b0;
      summary_rd   = 1'b0;
      out_data_nxt = pkt.data;
      case (state)
         arp_pkg::wait_summary, arp_pkg::pass_hdr: begin
            if (hdr_go) begin
               pkt_rd    = 1'b1;
               state_nxt = arp_pkg::pass_hdr;
               if (pkt.ctrl == '0) begin
                  // ethernet word 0 holds the mac addresses
                  if (summary.reply) begin
                     out_data_nxt = {summary.sender_mac, summary.our_mac[47:32]};
                     count_nxt    = 3'd1;
                     state_nxt    = arp_pkg::rewrite;
                  end else begin
                     state_nxt = arp_pkg::pass_rest;
                  end
               end else if (summary.reply && pkt.ctrl == arp_pkg::ioq_stage_ctrl) begin
                  out_data_nxt[arp_pkg::ioq_src_port_pos +: 16] = arp_pkg::dont_touch_src_port;
                  out_data_nxt[arp_pkg::ioq_dst_port_pos +: 16] = src_onehot; // back out
               end
            end
         end
         arp_pkg::rewrite: begin
            if (can_go) begin
               pkt_rd    = 1'b1;
               count_nxt = count + 3'd1;
               case (count)
                  3'd1: out_data_nxt[63:32] = summary.our_mac[31:0];
                  3'd2: out_data_nxt[31:0]  = {arp_pkg::arp_reply, summary.our_mac[47:32]};
                  3'd3: out_data_nxt        = {summary.our_mac[31:0], summary.target_ip};
                  3'd4: out_data_nxt        = {summary.sender_mac, summary.sender_ip[31:16]};
                  3'd5: out_data_nxt[63:48] = summary.sender_ip[15:0];
                  default: out_data_nxt     = pkt.data;
               endcase
               if (pkt.ctrl != '0) begin         // short packet ends early
                  summary_rd = 1'b1;
                  state_nxt  = arp_pkg::wait_summary;
               end else if (count == 3'd5) begin
                  state_nxt = arp_pkg::pass_rest;
               end
            end
         end
         arp_pkg::pass_rest: begin
            if (can_go) begin
               pkt_rd = 1'b1;
               if (pkt.ctrl != '0 && prev_is_0) begin
                  summary_rd = 1'b1;    // done with this packet
                  state_nxt  = arp_pkg::wait_summary;
               end
            end
         end
         default: state_nxt = arp_pkg::wait_summary;
      endcase
   end

   ////////////////////////////////////////
   // registered output
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state         <= arp_pkg::wait_summary;
         count         <= '0;
         prev_is_0     <= 1'b0;
         out_wr        <= 1'b0;
         out_word.ctrl <= 8'd1;
      end else begin
         state  <= state_nxt;
         count  <= count_nxt;
         out_wr <= pkt_rd;
         if (pkt_rd) begin
            out_word.ctrl <= pkt.ctrl;
            out_word.data <= out_data_nxt;
            prev_is_0     <= (pkt.ctrl == '0);
         end
      end
   end

endmodule

//--- source/arp_request_parser.sv
// arp request parser that inspects each accepted packet and pushes one reply summary
`timescale 1ns/1ps

module arp_request_parser (
   input  logic                  clk,
   input  logic                  reset,
   input  arp_pkg::pkt_word_t    in_word,
   input  logic                  in_wr,
   input  arp_pkg::arp_config_t  cfg,
   output arp_pkg::arp_summary_t summary,
   output logic                  summary_wr
);

   arp_pkg::parse_state_e state;
   arp_pkg::port_addr_t   entry;
   logic [15:0]           src_port;    // from the module header
   logic                  eop_seen;    // packet ended on the tpa_lo word
   logic                  last_word;
   logic                  port_ok;
   logic                  checking;
   logic                  word_ok;
   logic                  fail;

   assign last_word = (in_word.ctrl != '0);

   // only phys ports 0, 2, 4, 6 own a table entry
   assign port_ok = (src_port < 16'd8) && !src_port[0];
   assign entry   = cfg.port[src_port[2:1]];

   ////////////////////////////////////////
   // per state word check
   ////////////////////////////////////////
   always_comb begin
      checking = 1'b0;
      word_ok  = 1'b1;
      case (state)
         arp_pkg::skip_hdr: begin
            checking = in_wr && (in_word.ctrl == '0);   // first ethernet word
            word_ok  = cfg.enable;
         end
         arp_pkg::check_ethertype: begin
            checking = in_wr;
            word_ok  = (in_word.data[31:16] == arp_pkg::eth_type_arp) &&
                       (in_word.data[15:0] == arp_pkg::arp_hw_ethernet) && !last_word;
         end
         arp_pkg::check_op: begin
            checking = in_wr;
            word_ok  = (in_word.data[63:48] == arp_pkg::arp_proto_ip) &&
                       (in_word.data[31:16] == arp_pkg::arp_request) && !last_word;
         end
         arp_pkg::get_sender, arp_pkg::get_tpa_hi: begin
            checking = in_wr;
            word_ok  = !last_word;      // truncated request
         end
         default: begin
            checking = 1'b0;
            word_ok  = 1'b1;
         end
      endcase
   end

   assign fail = checking && !word_ok;

   ////////////////////////////////////////
   // walk the packet
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= arp_pkg::skip_hdr;
         summary_wr <= 1'b0;
         eop_seen   <= 1'b0;
      end else begin
         summary_wr <= 1'b0;
         if (fail) begin
            summary.reply <= 1'b0;   // not for us so pass it on
            summary_wr    <= 1'b1;
            state         <= last_word ? arp_pkg::skip_hdr : arp_pkg::wait_eop;
         end else begin
            case (state)
               arp_pkg::skip_hdr: begin
                  if (in_wr && in_word.ctrl == arp_pkg::ioq_stage_ctrl) begin
                     src_port <= in_word.data[arp_pkg::ioq_src_port_pos +: 16];
                  end
                  if (in_wr && in_word.ctrl == '0) state <= arp_pkg::check_ethertype;
               end
               arp_pkg::check_ethertype: begin
                  if (in_wr) state <= arp_pkg::check_op;
               end
               arp_pkg::check_op: begin
                  if (in_wr) begin
                     summary.sender_mac[47:32] <= in_word.data[15:0];
                     state                     <= arp_pkg::get_sender;
                  end
               end
               arp_pkg::get_sender: begin
                  if (in_wr) begin
                     summary.sender_mac[31:0] <= in_word.data[63:32];
                     summary.sender_ip        <= in_word.data[31:0];
                     state                    <= arp_pkg::get_tpa_hi;
                  end
               end
               arp_pkg::get_tpa_hi: begin
                  if (in_wr) begin
                     summary.target_ip[31:16] <= in_word.data[15:0];
                     state                    <= arp_pkg::get_tpa_lo;
                  end
               end
               arp_pkg::get_tpa_lo: begin
                  if (in_wr) begin
                     summary.target_ip[15:0] <= in_word.data[63:48];
                     eop_seen                <= last_word;
                     state                   <= arp_pkg::decide;
                  end
               end
               arp_pkg::decide: begin
                  summary.reply   <= cfg.enable && port_ok &&
                                     (summary.target_ip == entry.ip);
                  summary.our_mac <= entry.mac;
                  summary_wr      <= 1'b1;
                  // a word may still arrive here and close the packet
                  if (eop_seen || (in_wr && last_word)) state <= arp_pkg::skip_hdr;
                  else state <= arp_pkg::wait_eop;
               end
               arp_pkg::wait_eop: begin
                  if (in_wr && last_word) state <= arp_pkg::skip_hdr;
               end
               default: state <= arp_pkg::skip_hdr;
            endcase
         end
      end
   end

endmodule
